/* verif/fe_stim.txt */
// Records, hex: 1 addr insn opcode rd rs1 rs2 imm = program word and its expected decode
// 2 cycle target = redirect, 3 start len = credit hold-off, 4 cycles = run length, 0 = end
// Main block at 0x000
1 00000000 00500093 13 01 00 05 00000005
1 00000004 FFF08113 13 02 01 1F FFFFFFFF
1 00000008 123451B7 37 03 08 03 12345000
1 0000000C FFFFF217 17 04 1F 1F FFFFF000
1 00000010 0020A423 23 08 01 02 00000008
1 00000014 FE312E23 23 1C 02 03 FFFFFFFC
1 00000018 00208863 63 10 01 02 00000010
1 0000001C FE001CE3 63 19 00 00 FFFFFFF8
1 00000020 001000EF 6F 01 00 01 00000800
1 00000024 FFDFF06F 6F 00 1F 1D FFFFFFFC
1 00000028 00C082E7 67 05 01 0C 0000000C
1 0000002C 8003A303 03 06 07 00 FFFFF800
1 00000030 00A48433 33 08 09 0A 00000000
1 00000034 40D605B3 33 0B 0C 0D 00000000
1 00000038 1234560B 0B 0C 08 03 00000000
1 0000003C 7FFF8F93 13 1F 1F 1F 000007FF
// Second block at 0x080
1 00000080 F007E713 13 0E 0F 00 FFFFFF00
1 00000084 80000837 37 10 00 00 80000000
1 00000088 01190FA3 23 1F 12 11 0000001F
1 0000008C 8149C063 63 00 13 14 FFFFF000
// Redirects, cycles counted from reset release
2 0000001E 00000080
2 0000003C 00000000
2 00000064 00000084
2 00000096 00000200
2 000000B4 00000038
2 000000D2 0000000C
2 000000FA 00000010
// Hold-off windows, the redirects at 0x64 and 0xFA fall inside them
3 00000050 0000001E
3 000000F0 00000014
4 0000012C
0

/* flist.f */
rtl/fe_pkg.sv
rtl/decoded_if.sv
rtl/pc_gen.sv
rtl/if_reg.sv
rtl/id_decode.sv
rtl/id_reg.sv
rtl/fe_top.sv
verif/fe_tb.sv

/* Bender.yml */
package:
  name: fe_frontend

sources:
  - files:
      - rtl/fe_pkg.sv
      - rtl/decoded_if.sv
      - rtl/pc_gen.sv
      - rtl/if_reg.sv
      - rtl/id_decode.sv
      - rtl/id_reg.sv
      - rtl/fe_top.sv
  - target: test
    files:
      - verif/fe_tb.sv

/* verif/fe_tb.sv */
//****************************************************************************
// Front-end testbench driven by the program image and schedule in fe_stim.txt
// Checks issue order, decoded fields, the credit bound and redirects
//****************************************************************************
module fe_tb import fe_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_WORDS    = 256;   // 1 KB image window
    localparam int STIM_WORDS   = 1024;
    localparam int WD_FACTOR    = 50;    // Watchdog margin over the run length

    // Decoded fields of INSN_NOP (addi x0 x0 0)
    localparam opcode_t  NOP_OPCODE = OP_IMM;
    localparam reg_idx_t NOP_REG    = 5'd0;
    localparam word_t    NOP_IMM    = 32'h0;

    logic     clk;
    logic     rst;
    word_t    imem_addr;
    word_t    imem_data;
    logic     redirect_valid;
    word_t    redirect_pc;
    logic     issue_valid;
    word_t    issue_pc;
    opcode_t  issue_opcode;
    reg_idx_t issue_rd;
    reg_idx_t issue_rs1;
    reg_idx_t issue_rs2;
    word_t    issue_imm;
    logic     credit_return;

    // Program image and expected decode per word address
    word_t    imem    [0:MEM_WORDS-1];
    opcode_t  exp_op  [0:MEM_WORDS-1];
    reg_idx_t exp_rd  [0:MEM_WORDS-1];
    reg_idx_t exp_rs1 [0:MEM_WORDS-1];
    reg_idx_t exp_rs2 [0:MEM_WORDS-1];
    word_t    exp_imm [0:MEM_WORDS-1];
    word_t    stim_words [0:STIM_WORDS-1];  // Raw records from the data file

    int          red_cycle[$];
    word_t       red_target[$];
    int          hold_start[$];   // Windows with no credit returns
    int          hold_len[$];
    int          run_cycles;
    int          cyc;
    int          outstanding;     // Issued minus returned
    int          issued;
    word_t       exp_pc;          // PC the next issue must carry
    logic        target_pending;  // Redirect target not issued yet
    longint      wd_limit;
    logic        stim_ready;
    int          seed;
    int unsigned dummy;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Combinational memory returning NOP outside the window
    assign imem_data = (imem_addr < MEM_WORDS * 4) ? imem[imem_addr[9:2]] : INSN_NOP;

    fe_top UUT (
        .clk            (clk),
        .rst            (rst),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .issue_valid    (issue_valid),
        .issue_pc       (issue_pc),
        .issue_opcode   (issue_opcode),
        .issue_rd       (issue_rd),
        .issue_rs1      (issue_rs1),
        .issue_rs2      (issue_rs2),
        .issue_imm      (issue_imm),
        .credit_return  (credit_return)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s expected %h got %h at cycle %0d",
                               name, exp, act, cyc));
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s expected %h got %h at cycle %0d",
                               name, exp, act, cyc));
    endtask

    task automatic check_opcode(input string name, input opcode_t exp, input opcode_t act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s expected %h got %h at cycle %0d",
                               name, exp, act, cyc));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("CHECK FAILED %s expected %h got %h at cycle %0d",
                               name, exp, act, cyc));
    endtask

    // Index of the redirect scheduled for cycle c or -1
    function automatic int redirect_index(input int c);
        int k;
        redirect_index = -1;
        for (k = 0; k < red_cycle.size(); k++) begin
            if (red_cycle[k] == c) redirect_index = k;
        end
    endfunction

    function automatic logic in_hold(input int c);
        int k;
        in_hold = 1'b0;
        for (k = 0; k < hold_start.size(); k++) begin
            if (c >= hold_start[k] && c < hold_start[k] + hold_len[k]) in_hold = 1'b1;
        end
    endfunction

    function automatic logic hold_last(input int c);
        int k;
        hold_last = 1'b0;
        for (k = 0; k < hold_start.size(); k++) begin
            if (c == hold_start[k] + hold_len[k] - 1) hold_last = 1'b1;
        end
    endfunction

    // Record kinds are 1 program, 2 redirect, 3 hold-off, 4 run length and 0 end
    task automatic load_stim();
        int    i;
        int    p;
        int    w;
        word_t kind;
        for (i = 0; i < STIM_WORDS; i++) begin
            stim_words[i] = '0;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i]    = INSN_NOP;
            exp_op[i]  = NOP_OPCODE;
            exp_rd[i]  = NOP_REG;
            exp_rs1[i] = NOP_REG;
            exp_rs2[i] = NOP_REG;
            exp_imm[i] = NOP_IMM;
        end
        run_cycles = 0;
        $readmemh("verif/fe_stim.txt", stim_words);
        p = 0;
        while (p < STIM_WORDS && stim_words[p] != '0) begin
            kind = stim_words[p];
            case (kind)
                32'd1: begin
                    if (stim_words[p+1] >= MEM_WORDS * 4)
                        fail_run("Program address lies outside the memory model");
                    w          = int'(stim_words[p+1] >> 2);
                    imem[w]    = stim_words[p+2];
                    exp_op[w]  = opcode_t'(stim_words[p+3]);
                    exp_rd[w]  = reg_idx_t'(stim_words[p+4]);
                    exp_rs1[w] = reg_idx_t'(stim_words[p+5]);
                    exp_rs2[w] = reg_idx_t'(stim_words[p+6]);
                    exp_imm[w] = stim_words[p+7];
                    p = p + 8;
                end
                32'd2: begin
                    red_cycle.push_back(int'(stim_words[p+1]));
                    red_target.push_back(stim_words[p+2]);
                    p = p + 3;
                end
                32'd3: begin
                    hold_start.push_back(int'(stim_words[p+1]));
                    hold_len.push_back(int'(stim_words[p+2]));
                    p = p + 3;
                end
                32'd4: begin
                    run_cycles = int'(stim_words[p+1]);
                    p = p + 2;
                end
                default: fail_run("Unknown record kind in the stimulus file");
            endcase
        end
        if (run_cycles == 0) fail_run("Stimulus file missing or without a run length");
    endtask

    // Drives the inputs of cycle c on its rising edge
    task automatic drive_cycle(input int c);
        int   k;
        logic ret;
        k   = redirect_index(c);
        ret = 1'b0;
        if (!in_hold(c) && outstanding > 0) ret = ($urandom % 2) != 0;  // Back end frees a slot
        if (k >= 0) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= red_target[k];
        end else begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end
        credit_return <= ret;
    endtask

    // Scoreboard for cycle c at the falling edge
    task automatic check_cycle(input int c);
        int w;
        if (c == 0) begin
            check_word("imem_addr", RESET_PC, imem_addr);  // Still the reset PC
            check_flag("issue_valid", 1'b0, issue_valid);
        end
        // Nothing may go out without a free slot
        if (outstanding >= int'(CREDITS)) check_flag("issue_valid", 1'b0, issue_valid);
        if (issue_valid) begin
            check_word("issue_pc", exp_pc, issue_pc);
            if (exp_pc < MEM_WORDS * 4) begin
                w = int'(exp_pc >> 2);
                check_opcode("issue_opcode", exp_op[w], issue_opcode);
                check_reg_idx("issue_rd", exp_rd[w], issue_rd);
                check_reg_idx("issue_rs1", exp_rs1[w], issue_rs1);
                check_reg_idx("issue_rs2", exp_rs2[w], issue_rs2);
                check_word("issue_imm", exp_imm[w], issue_imm);
            end else begin
                check_opcode("issue_opcode", NOP_OPCODE, issue_opcode);
                check_reg_idx("issue_rd", NOP_REG, issue_rd);
                check_reg_idx("issue_rs1", NOP_REG, issue_rs1);
                check_reg_idx("issue_rs2", NOP_REG, issue_rs2);
                check_word("issue_imm", NOP_IMM, issue_imm);
            end
            exp_pc         = exp_pc + 32'd4;  // Sequential successor
            issued         = issued + 1;
            outstanding    = outstanding + 1;
            target_pending = 1'b0;
        end
        if (credit_return) outstanding = outstanding - 1;
        // Only an issue in the redirect cycle belongs to the old path
        if (redirect_valid) begin
            if (target_pending)
                fail_run($sformatf("Redirect target %h never issued before cycle %0d",
                                   exp_pc, c));
            exp_pc         = redirect_pc;
            target_pending = 1'b1;
        end
        if (hold_last(c) && outstanding != int'(CREDITS))
            fail_run($sformatf("Front end did not fill all credits by cycle %0d", c));
    endtask

    initial begin : main
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        credit_return  = 1'b0;
        stim_ready     = 1'b0;
        outstanding    = 0;
        issued         = 0;
        cyc            = 0;
        exp_pc         = RESET_PC;
        target_pending = 1'b0;
        seed           = 17;
        dummy          = $urandom(seed);
        load_stim();
        wd_limit   = longint'(WD_FACTOR) * (RESET_CYCLES + run_cycles) * CLK_PERIOD;
        stim_ready = 1'b1;
        @(posedge clk);
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_flag("issue_valid", 1'b0, issue_valid);  // Quiet during reset
            @(posedge clk);
        end
        rst <= 1'b0;
        for (cyc = 0; cyc < run_cycles; cyc++) begin
            if (cyc > 0) @(posedge clk);
            drive_cycle(cyc);
            @(negedge clk);
            check_cycle(cyc);
        end
        if (issued == 0) begin
            fail_run("No instruction was issued during the run");
        end else if (target_pending) begin
            fail_run("The target of the last redirect was never issued");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    initial begin : watchdog
        wait (stim_ready);
        #(wd_limit);
        $display("Watchdog expired, the run did not finish in time");
        $display("tests failed");
        $fatal(1, "timeout");
    end

endmodule

/* rtl/fe_top.sv */
//****************************************************************************
// Front end top level, fetch, IF/ID, decode and ID/EX chained together
// Instruction memory is external and must answer in the address cycle
//****************************************************************************
module fe_top import fe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // Instruction memory
    output word_t    imem_addr,
    input  word_t    imem_data,
    // Redirect from back end
    input  logic     redirect_valid,
    input  word_t    redirect_pc,
    // Issue toward back end
    output logic     issue_valid,
    output word_t    issue_pc,
    output opcode_t  issue_opcode,
    output reg_idx_t issue_rd,
    output reg_idx_t issue_rs1,
    output reg_idx_t issue_rs2,
    output word_t    issue_imm,
    input  logic     credit_return   // One slot freed per cycle high
);

    logic  stall;     // From ID/EX back-pressure
    word_t if_pc;
    word_t if_insn;
    logic  if_en;

    decoded_if dec_bus ();

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_pc       (imem_addr)
    );

    if_reg u_if_reg (
        .clk     (clk),
        .rst     (rst),
        .insn    (imem_data),
        .stall   (stall),
        .flush   (redirect_valid),
        .new_pc  (redirect_pc),
        .if_pc   (if_pc),
        .if_insn (if_insn),
        .if_en   (if_en)
    );

    id_decode u_id_decode (
        .if_pc   (if_pc),
        .if_insn (if_insn),
        .if_en   (if_en),
        .dec     (dec_bus.src)
    );

    id_reg u_id_reg (
        .clk           (clk),
        .rst           (rst),
        .dec           (dec_bus.dst),
        .flush         (redirect_valid),
        .credit_return (credit_return),
        .stall         (stall),
        .issue_valid   (issue_valid),
        .issue_pc      (issue_pc),
        .issue_opcode  (issue_opcode),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm)
    );

endmodule

/* rtl/id_reg.sv */
//****************************************************************************
// ID/EX register with credit counter toward the back end
// Issues the held item while credits remain, else stalls the front end
//****************************************************************************
module id_reg import fe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    decoded_if.dst   dec,
    input  logic     flush,          // Redirect, drops the held item
    input  logic     credit_return,  // One back-end slot freed
    output logic     stall,
    output logic     issue_valid,
    output word_t    issue_pc,
    output opcode_t  issue_opcode,
    output reg_idx_t issue_rd,
    output reg_idx_t issue_rs1,
    output reg_idx_t issue_rs2,
    output word_t    issue_imm
);

    logic    valid_q;   // Holds a real item
    credit_t credits;   // Free back-end slots
    logic    load;

    // Item goes out whenever a slot is free
    assign issue_valid = valid_q && (credits != '0);

    // Full and no slot left, freeze fetch and IF/ID
    assign stall = valid_q && (credits == '0);

    // Take a new item when empty or when the current one leaves now
    assign load = !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;       // Wrong-path item dropped
        end else if (load) begin
            valid_q <= dec.valid;
        end
    end

    // Payload, no reset needed
    always_ff @(posedge clk) begin
        if (load) begin
            issue_pc     <= dec.pc;
            issue_opcode <= dec.opcode;
            issue_rd     <= dec.rd;
            issue_rs1    <= dec.rs1;
            issue_rs2    <= dec.rs2;
            issue_imm    <= dec.imm;
        end
    end

    // Spend on issue, refill on return, both may hit in one cycle.
    // An issue in the redirect cycle still counts, flush leaves this alone
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDITS;
        end else begin
            credits <= credits - credit_t'(issue_valid) + credit_t'(credit_return);
        end
    end

endmodule

/* rtl/id_decode.sv */
//****************************************************************************
// Combinational decoder, IF/ID contents to opcode, registers and immediate
// Unknown opcodes pass through with a zero immediate
//****************************************************************************
module id_decode import fe_pkg::*; (
    input  word_t if_pc,
    input  word_t if_insn,
    input  logic  if_en,
    decoded_if.src dec
);

    opcode_t opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    word_t   imm;

    assign opcode = if_insn[6:0];

    // I-type, insn[31:20]
    assign imm_i = {{20{if_insn[31]}}, if_insn[31:20]};

    // S-type, split across funct7 and rd fields
    assign imm_s = {{20{if_insn[31]}}, if_insn[31:25], if_insn[11:7]};

    // B-type, bit 0 always zero
    assign imm_b = {{19{if_insn[31]}}, if_insn[31], if_insn[7],
                    if_insn[30:25], if_insn[11:8], 1'b0};

    // U-type, no sign extension needed
    assign imm_u = {if_insn[31:12], 12'h000};

    // J-type, bit 0 always zero
    assign imm_j = {{11{if_insn[31]}}, if_insn[31], if_insn[19:12],
                    if_insn[20], if_insn[30:21], 1'b0};

    // Format select by major opcode
    always_comb begin
        case (opcode)
            OP_IMM,
            OP_LOAD,
            OP_JALR:   imm = imm_i;
            OP_STORE:  imm = imm_s;
            OP_BRANCH: imm = imm_b;
            OP_LUI,
            OP_AUIPC:  imm = imm_u;
            OP_JAL:    imm = imm_j;
            default:   imm = '0;  // OP_REG and anything unknown
        endcase
    end

    // Register fields at fixed RV32I positions,
    // extracted even where the format does not use them
    assign dec.rd     = if_insn[11:7];
    assign dec.rs1    = if_insn[19:15];
    assign dec.rs2    = if_insn[24:20];
    assign dec.opcode = opcode;
    assign dec.imm    = imm;

    // Valid mark and PC pass straight through
    assign dec.valid  = if_en;
    assign dec.pc     = if_pc;

endmodule

/* rtl/if_reg.sv */
//****************************************************************************
// IF/ID pipeline register, holds fetched word, its PC and valid mark
// Stalls with the front end, flush to new_pc overrides stall
//****************************************************************************
module if_reg import fe_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t insn,     // Memory word for the current fetch PC
    input  logic  stall,
    input  logic  flush,    // Redirect from back end
    input  word_t new_pc,   // Redirect target
    output word_t if_pc,    // PC of the held instruction
    output word_t if_insn,  // Held instruction
    output logic  if_en     // Valid mark
);

    word_t pc_capture;

    // PC of the word on insn this cycle.
    // While empty (after reset or flush) if_pc already equals the fetch PC,
    // otherwise fetch runs one word ahead of the held item
    assign pc_capture = if_en ? (if_pc + PC_STEP) : if_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_pc   <= RESET_PC;
            if_insn <= INSN_NOP;
            if_en   <= 1'b0;
        end else if (flush) begin
            // Flush beats stall so a redirect is never dropped
            if_pc   <= new_pc;      // Fetch restarts here too
            if_insn <= INSN_NOP;
            if_en   <= 1'b0;
        end else if (!stall) begin
            if_pc   <= pc_capture;
            if_insn <= insn;
            if_en   <= 1'b1;
        end
        // Stalled, everything holds
    end

endmodule

/* rtl/pc_gen.sv */
//****************************************************************************
// Fetch PC register, drives the instruction memory address
// Steps by one word per free cycle, redirect wins over stall
//****************************************************************************
module pc_gen import fe_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,           // Back-pressure from ID/EX
    input  logic  redirect_valid,  // Branch or exception restart
    input  word_t redirect_pc,     // Restart target
    output word_t fetch_pc         // To imem_addr via top level
);

    word_t pc_q;
    word_t pc_next;

    // Next fetch address
    always_comb begin
        if (redirect_valid) begin
            pc_next = redirect_pc;      // Taken even while stalled
        end else if (stall) begin
            pc_next = pc_q;             // Hold, memory word re-read next cycle
        end else begin
            pc_next = pc_q + PC_STEP;   // Sequential fetch
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // Memory is combinational, so the word for pc_q
    // comes back in this same cycle
    assign fetch_pc = pc_q;

endmodule

/* rtl/decoded_if.sv */
//****************************************************************************
// One decoded instruction, decoder (src) to ID/EX register (dst)
//****************************************************************************
interface decoded_if import fe_pkg::*; ();

    logic     valid;  // Item carries a real instruction
    word_t    pc;     // Address of the instruction
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;    // Already sign-extended by format

    // Decoder side drives everything
    modport src (output valid, pc, opcode, rd, rs1, rs2, imm);

    // Register side only samples
    modport dst (input valid, pc, opcode, rd, rs1, rs2, imm);

endinterface

/* rtl/fe_pkg.sv */
//****************************************************************************
// Shared types and constants of the fetch/decode front end
// Imported by wildcard into every module and interface of the design
//****************************************************************************
package fe_pkg;

    // Basic vector types
    typedef logic [31:0] word_t;    // Instruction, PC or immediate
    typedef logic [4:0]  reg_idx_t; // Architectural register index
    typedef logic [6:0]  opcode_t;  // Major opcode, insn[6:0]
    typedef logic [2:0]  credit_t;  // Must hold the value CREDITS

    // Major opcodes, RV32I encodings
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // Back-end buffer slots, one credit per slot
    localparam credit_t CREDITS = 3'd4;

    // Fetch starts here after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // Sequential fetch step, one 32-bit word
    localparam word_t PC_STEP = 32'd4;

    // addi x0, x0, 0
    // Placed in the IF/ID register on reset and flush
    localparam word_t INSN_NOP = 32'h0000_0013;

endpackage
